//--- logic/serdes_params.svh
`ifndef SERDES_PARAMS_SVH
`define SERDES_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample format

`define SERDES_BIT_WIDTH 16          // Bits per signed sample

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame format

`define SERDES_N_SAMPLES 4           // Samples per frame

// Index into a frame, clog2 of the frame length
`define SERDES_IDX_W 2

`endif

//--- logic/serdes_pkg.sv
`default_nettype none

`include "serdes_params.svh"

package serdes_pkg;

  typedef logic signed [`SERDES_BIT_WIDTH-1:0] sample_t;

  typedef sample_t [`SERDES_N_SAMPLES-1:0] sample_frame_t;  // Slot 0 is the first sample

  typedef enum logic [1:0] {
    LANE_PASS   = 2'd0,
    LANE_NEGATE = 2'd1,                // Saturates the most negative value
    LANE_HALVE  = 2'd2,                // Arithmetic shift right by one
    LANE_ABS    = 2'd3
  } lane_op_e;

  typedef enum logic {
    DES_COLLECT = 1'b0,
    DES_HOLD    = 1'b1
  } des_state_e;

  typedef enum logic {
    SER_LOAD = 1'b0,
    SER_SEND = 1'b1
  } ser_state_e;

endpackage

`default_nettype wire

//--- logic/serdes_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "serdes_params.svh"

module serdes_deserializer (
  input  logic                      clk,
  input  logic                      reset,

  input  logic                      recv_val,
  input  serdes_pkg::sample_t       recv_data,
  input  serdes_pkg::lane_op_e      recv_op,
  output logic                      recv_rdy,

  output logic                      frame_val,
  output serdes_pkg::sample_frame_t frame_data,
  output serdes_pkg::lane_op_e      frame_op,
  input  logic                      frame_rdy
);
  import serdes_pkg::*;

  des_state_e              state;
  logic [`SERDES_IDX_W-1:0] idx;
  logic                    recv_xfer;
  logic                    last_slot;

  assign recv_rdy  = (state == DES_COLLECT);
  assign frame_val = (state == DES_HOLD);

  assign recv_xfer = recv_val && recv_rdy;
  assign last_slot = (idx == `SERDES_IDX_W'(`SERDES_N_SAMPLES - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DES_COLLECT;
      idx   <= '0;
    end else begin
      case (state)
        DES_COLLECT: begin
          if (recv_xfer) begin
            if (last_slot) begin
              state <= DES_HOLD;                 // Frame complete
              idx   <= '0;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        DES_HOLD: begin
          if (frame_rdy) state <= DES_COLLECT;   // Serializer took the frame
        end
        default: begin
          state <= DES_COLLECT;
          idx   <= '0;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame storage

  always_ff @(posedge clk) begin
    if (recv_xfer) begin
      frame_data[idx] <= recv_data;
      if (idx == '0) frame_op <= recv_op;        // Opcode rides with sample 0
    end
  end

endmodule

`default_nettype wire

//--- logic/serdes_sample_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "serdes_params.svh"

module serdes_sample_lane (
  input  serdes_pkg::lane_op_e op,
  input  serdes_pkg::sample_t  sample_in,
  output serdes_pkg::sample_t  sample_out
);
  import serdes_pkg::*;

  localparam sample_t SAMPLE_MIN = {1'b1, {(`SERDES_BIT_WIDTH - 1){1'b0}}};
  localparam sample_t SAMPLE_MAX = {1'b0, {(`SERDES_BIT_WIDTH - 1){1'b1}}};

  sample_t negated;
  sample_t halved;
  sample_t magnitude;

  // -MIN does not fit, clamp it to MAX
  always_comb begin
    if (sample_in == SAMPLE_MIN) begin
      negated = SAMPLE_MAX;
    end else begin
      negated = -sample_in;
    end
  end

  assign halved    = sample_in >>> 1;                     // Rounds toward -inf
  assign magnitude = sample_in[`SERDES_BIT_WIDTH-1] ? negated : sample_in;

  always_comb begin
    case (op)
      LANE_PASS:   sample_out = sample_in;
      LANE_NEGATE: sample_out = negated;
      LANE_HALVE:  sample_out = halved;
      LANE_ABS:    sample_out = magnitude;
      default:     sample_out = sample_in;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/serdes_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "serdes_params.svh"

module serdes_serializer (
  input  logic                      clk,
  input  logic                      reset,

  input  logic                      frame_val,
  output logic                      frame_rdy,
  input  serdes_pkg::sample_frame_t lane_data,

  output logic                      send_val,
  output serdes_pkg::sample_t       send_data,
  input  logic                      send_rdy
);
  import serdes_pkg::*;

  ser_state_e               state;
  ser_state_e               state_next;
  logic [`SERDES_IDX_W-1:0] idx;
  logic [`SERDES_IDX_W:0]   idx_next;      // One bit wider to reach N_SAMPLES
  logic                     reg_en;
  sample_frame_t            reg_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sample registers

  for (genvar i = 0; i < `SERDES_N_SAMPLES; i++) begin : g_reg
    always_ff @(posedge clk) begin
      if (reg_en) reg_q[i] <= lane_data[i];
    end
  end

  assign send_data = reg_q[idx];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control

  always_comb begin
    reg_en    = 1'b0;
    frame_rdy = 1'b0;
    send_val  = 1'b0;
    idx_next  = {1'b0, idx};
    case (state)
      SER_LOAD: begin
        reg_en    = 1'b1;                  // Track the lanes until a frame lands
        frame_rdy = 1'b1;
        idx_next  = '0;
      end
      SER_SEND: begin
        send_val = 1'b1;
        if (send_rdy) idx_next = {1'b0, idx} + 1'b1;
      end
      default: begin
        idx_next = '0;
      end
    endcase
  end

  always_comb begin
    case (state)
      SER_LOAD: state_next = frame_val ? SER_SEND : SER_LOAD;
      SER_SEND: begin
        if (idx_next == (`SERDES_IDX_W + 1)'(`SERDES_N_SAMPLES)) begin
          state_next = SER_LOAD;           // Last sample accepted
        end else begin
          state_next = SER_SEND;
        end
      end
      default:  state_next = SER_LOAD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SER_LOAD;
      idx   <= '0;
    end else begin
      state <= state_next;
      if (state_next == SER_LOAD) begin
        idx <= '0;
      end else begin
        idx <= idx_next[`SERDES_IDX_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/serdes_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "serdes_params.svh"

module serdes_top (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 recv_val,
  input  serdes_pkg::sample_t  recv_data,
  input  serdes_pkg::lane_op_e recv_op,
  output logic                 recv_rdy,

  output logic                 send_val,
  output serdes_pkg::sample_t  send_data,
  input  logic                 send_rdy
);
  import serdes_pkg::*;

  logic          frame_val;
  logic          frame_rdy;
  sample_frame_t frame_data;
  lane_op_e      frame_op;
  sample_frame_t lane_data;

  serdes_deserializer u_deserializer (
    .clk        (clk),
    .reset      (reset),
    .recv_val   (recv_val),
    .recv_data  (recv_data),
    .recv_op    (recv_op),
    .recv_rdy   (recv_rdy),
    .frame_val  (frame_val),
    .frame_data (frame_data),
    .frame_op   (frame_op),
    .frame_rdy  (frame_rdy)
  );

  // One lane per sample slot, all sharing the frame opcode
  for (genvar i = 0; i < `SERDES_N_SAMPLES; i++) begin : g_lane
    serdes_sample_lane u_lane (
      .op         (frame_op),
      .sample_in  (frame_data[i]),
      .sample_out (lane_data[i])
    );
  end

  serdes_serializer u_serializer (
    .clk        (clk),
    .reset      (reset),
    .frame_val  (frame_val),
    .frame_rdy  (frame_rdy),
    .lane_data  (lane_data),
    .send_val   (send_val),
    .send_data  (send_data),
    .send_rdy   (send_rdy)
  );

endmodule

`default_nettype wire

//--- tb/serdes_checker.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_checker (
  input logic                clk,
  input logic                reset,
  input logic                recv_rdy,
  input logic                send_val,
  input serdes_pkg::sample_t send_data,
  input logic                send_rdy
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output handshake

  a_data_stable: assert property (@(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> $stable(send_data))
    else $error("send_data changed while send_rdy was low");

  a_val_held: assert property (@(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> send_val)
    else $error("send_val dropped before a transfer");

  // Synchronous reset lands one edge later
  a_reset_values: assert property (@(posedge clk)
    reset |=> (recv_rdy && !send_val))
    else $error("recv_rdy or send_val wrong after reset");

endmodule

bind serdes_top serdes_checker u_checker (
  .clk       (clk),
  .reset     (reset),
  .recv_rdy  (recv_rdy),
  .send_val  (send_val),
  .send_data (send_data),
  .send_rdy  (send_rdy)
);

`default_nettype wire

//--- tb/serdes_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "serdes_params.svh"

module serdes_tb;
  import serdes_pkg::*;

  localparam int MAX_TESTS = 32;
  localparam int N = `SERDES_N_SAMPLES;

  logic     clk;
  logic     reset;
  logic     recv_val;
  sample_t  recv_data;
  lane_op_e recv_op;
  logic     recv_rdy;
  logic     send_val;
  sample_t  send_data;
  logic     send_rdy;

  string    names [MAX_TESTS];
  lane_op_e ops [MAX_TESTS];
  sample_t  in_s [MAX_TESTS][N];
  sample_t  exp_s [MAX_TESTS][N];
  int       gaps [MAX_TESTS][N];
  lane_op_e noise [MAX_TESTS][N];         // Opcodes on samples 1..N-1, must be ignored
  int       test_errs [MAX_TESTS];
  int       out_count [MAX_TESTS];

  sample_t  exp_q [$];
  int       tid_q [$];
  integer   seed;
  int       n_tests = 0;
  int       tests_done = 0;
  int       n_pass = 0;
  int       n_fail = 0;
  int       errors = 0;
  int       cycles = 0;
  int       limit = 100;
  logic     started = 1'b0;
  logic     stalled = 1'b0;
  sample_t  held_data;

  serdes_top u_serdes_top (
    .clk       (clk),
    .reset     (reset),
    .recv_val  (recv_val),
    .recv_data (recv_data),
    .recv_op   (recv_op),
    .recv_rdy  (recv_rdy),
    .send_val  (send_val),
    .send_data (send_data),
    .send_rdy  (send_rdy)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test vectors

  task automatic load_tests();
    int          fd;
    int          op_val;
    int          k;
    int          got;
    logic [31:0] word;
    logic [31:0] r;
    string       tok;
    string       rest;
    fd = $fopen("tb/serdes_tests.txt", "r");
    assert (fd != 0) else begin
      $display("ERROR could not open tb/serdes_tests.txt");
      errors++;
    end
    if (fd != 0) begin
      while (n_tests < MAX_TESTS && $fscanf(fd, "%s", tok) == 1) begin
        if (tok[0] == "#") begin
          void'($fgets(rest, fd));             // Skip comment line
        end else begin
          got = $fscanf(fd, "%d", op_val);
          names[n_tests] = tok;
          ops[n_tests] = lane_op_e'(op_val[1:0]);
          for (k = 0; k < 2 * N; k++) begin
            got += $fscanf(fd, "%h", word);
            if (k < N) in_s[n_tests][k] = word[`SERDES_BIT_WIDTH-1:0];
            else exp_s[n_tests][k - N] = word[`SERDES_BIT_WIDTH-1:0];
          end
          assert (got == 2 * N + 1) else begin
            $display("ERROR test line %s is incomplete", tok);
            errors++;
          end
          for (k = 0; k < N; k++) begin
            gaps[n_tests][k] = $unsigned($random(seed)) % 3;
            r = $random(seed);
            noise[n_tests][k] = lane_op_e'(r[1:0]);
          end
          n_tests++;
        end
      end
      $fclose(fd);
    end
    assert (n_tests > 0) else begin
      $display("ERROR no tests found in the tests file");
      errors++;
    end
    limit = 64 * n_tests + 100;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus

  task automatic drive_test(input int t);
    int   k;
    logic taken;
    for (k = 0; k < N; k++) begin
      exp_q.push_back(exp_s[t][k]);
      tid_q.push_back(t);
    end
    for (k = 0; k < N; k++) begin
      repeat (gaps[t][k]) begin
        @(posedge clk);
        #1;
      end
      recv_val  = 1'b1;
      recv_data = in_s[t][k];
      recv_op   = (k == 0) ? ops[t] : noise[t][k];
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = recv_rdy;                      // Transfer happens on the next edge
        @(posedge clk);
        #1;
      end
      recv_val = 1'b0;
    end
  endtask

  initial begin
    seed      = 32'h6c2c8997;
    reset     = 1'b1;
    recv_val  = 1'b0;
    recv_data = '0;
    recv_op   = LANE_PASS;
    send_rdy  = 1'b1;
    load_tests();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (!send_val && recv_rdy) else begin
      $display("ERROR outputs not at reset values after reset");
      errors++;
    end
    started = 1'b1;
    for (int t = 0; t < n_tests; t++) drive_test(t);
    wait (tests_done == n_tests);
    @(posedge clk);
    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             n_tests, n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0 && n_pass == n_tests) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Random back-pressure on the output
  initial begin
    wait (started);
    forever begin
      @(posedge clk);
      #1;
      send_rdy = (($random(seed) & 3) != 0);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitor

  task automatic check_output();
    sample_t exp_v;
    int      t;
    assert (exp_q.size() != 0) else begin
      $display("ERROR output sample %h arrived with nothing expected", send_data);
      errors++;
    end
    if (exp_q.size() != 0) begin
      exp_v = exp_q.pop_front();
      t = tid_q.pop_front();
      assert (send_data == exp_v) else begin
        $display("MISMATCH %s expected %h actual %h", names[t], exp_v, send_data);
        errors++;
        test_errs[t]++;
      end
      out_count[t]++;
      if (out_count[t] == N) begin
        if (test_errs[t] == 0) n_pass++;
        else n_fail++;
        $display("test %-16s %s", names[t], (test_errs[t] == 0) ? "ok" : "bad");
        tests_done++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      if (stalled) begin
        assert (send_val && send_data == held_data) else begin
          $display("ERROR output dropped or changed while send_rdy was low");
          errors++;
        end
      end
      stalled   = send_val && !send_rdy;
      held_data = send_data;
      if (send_val && send_rdy) check_output();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("ERROR run timed out after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb/serdes_tests.txt
# name op(0 pass, 1 negate, 2 halve, 3 abs) in0 in1 in2 in3 exp0 exp1 exp2 exp3
# samples are 16-bit two's complement hex, in0 is sent first
pass_count      0 0001 0002 0003 0004 0001 0002 0003 0004
pass_extremes   0 7fff 8000 0000 ffff 7fff 8000 0000 ffff
negate_small    1 0001 fffe 0064 0000 ffff 0002 ff9c 0000
negate_limits   1 8000 7fff 8001 ffff 7fff 8001 7fff 0001
halve_pos       2 0004 0005 7fff 0001 0002 0002 3fff 0000
halve_neg       2 ffff fffd 8000 fffe ffff fffe c000 ffff
abs_small       3 0005 fffb 0000 7fff 0005 0005 0000 7fff
abs_limits      3 8000 8001 ffff 1234 7fff 7fff 0001 1234
switch_negate   1 1000 2000 3000 4000 f000 e000 d000 c000
switch_halve    2 1000 2000 3000 4000 0800 1000 1800 2000
switch_abs      3 c000 4000 8000 ffff 4000 4000 7fff 0001
switch_pass     0 c000 4000 8000 ffff c000 4000 8000 ffff
negate_mixed    1 1234 edcc 0001 8000 edcc 1234 ffff 7fff
halve_odd       2 0003 fff9 0009 8001 0001 fffc 0004 c000

//--- filelist.f
+incdir+logic
logic/serdes_pkg.sv
logic/serdes_deserializer.sv
logic/serdes_sample_lane.sv
logic/serdes_serializer.sv
logic/serdes_top.sv
tb/serdes_checker.sv
tb/serdes_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := serdes_tb
RTL_TOP    := serdes_top
FILELIST   := filelist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
